//--- logic/cpuTypes.sv
package cpuTypes;

    // Major opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0D
    } InstOp;

    // R-type function code, inst[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } InstFn;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_NOP
    } AluOp;

    typedef struct packed {
        AluOp aluOp;            // ALU operation
        logic aluSrcB;          // Operand B from immediate
        logic regDst;           // Destination is rd, else rt
        logic regWrEnable;      // Result goes to register file
        logic zeroExtImm;       // ORI style immediate
    } CtrlWord;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pcPlus4;
    } FetchItem;

endpackage

//--- logic/instLink.sv
`timescale 1ns/1ns

interface instLink;

    logic        req;       // Data valid, held until ack
    logic        ack;
    logic [31:0] inst;
    logic [31:0] pcPlus4;

    modport source (
        output req,
        output inst,
        output pcPlus4,
        input  ack
    );

    modport sink (
        input  req,
        input  inst,
        input  pcPlus4,
        output ack
    );

endinterface

//--- logic/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit (
    input  logic        i_Clock,
    input  logic        i_rst,
    input  logic        i_InstReq,
    input  logic [31:0] i_InstData,
    output logic        o_InstAck,
    instLink.source     linkOut
);

    typedef enum logic [1:0] {Idle, HostAck, LinkReq, LinkDone} FetchState;

    FetchState   state;
    logic [31:0] pcCount;                           // PC of the last accepted instruction plus 4

    assign linkOut.pcPlus4 = pcCount;               // Only changes in Idle, so stable under req

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            state       <= Idle;
            pcCount     <= '0;
            o_InstAck   <= 1'b0;
            linkOut.req <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (i_InstReq) begin
                        linkOut.inst <= i_InstData;  // Capture word from host
                        pcCount      <= pcCount + 32'd4;
                        o_InstAck    <= 1'b1;
                        state        <= HostAck;
                    end
                end
                HostAck: begin
                    if (!i_InstReq) begin            // Host released, close its handshake
                        o_InstAck   <= 1'b0;
                        linkOut.req <= 1'b1;
                        state       <= LinkReq;
                    end
                end
                LinkReq: begin
                    if (linkOut.ack) begin
                        linkOut.req <= 1'b0;
                        state       <= LinkDone;
                    end
                end
                default: begin                       // LinkDone
                    if (!linkOut.ack) state <= Idle;
                end
            endcase
        end
    end

endmodule

//--- logic/instQueue.sv
`timescale 1ns/1ns

module instQueue #(
    parameter type tItem = cpuTypes::FetchItem,
    parameter int  Depth = 4
) (
    input  logic    i_Clock,
    input  logic    i_rst,
    instLink.sink   linkIn,
    instLink.source linkOut
);

    localparam int PtrBits = $clog2(Depth);

    tItem                 mem [Depth];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic [PtrBits:0]     count;
    logic                 push;
    logic                 pop;
    logic                 outWait;                   // Waiting for sink to drop ack
    logic [$bits(tItem)-1:0] headBits;

    // Input side accepts a new item only while its ack is low
    assign push = linkIn.req && !linkIn.ack && (count != Depth[PtrBits:0]);
    assign pop  = linkOut.req && linkOut.ack;

    always_ff @(posedge i_Clock) begin
        if (push) mem[wrPtr] <= tItem'({linkIn.inst, linkIn.pcPlus4});
        if (!linkOut.req && !outWait && count != '0) headBits <= mem[rdPtr];
    end

    assign {linkOut.inst, linkOut.pcPlus4} = headBits;  // Unpack registered head

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            linkIn.ack  <= 1'b0;
            linkOut.req <= 1'b0;
            outWait     <= 1'b0;
        end else begin
            if (push) begin
                wrPtr      <= wrPtr + 1'b1;
                linkIn.ack <= 1'b1;
            end else if (linkIn.ack && !linkIn.req) begin
                linkIn.ack <= 1'b0;
            end

            if (pop) begin
                linkOut.req <= 1'b0;
                rdPtr       <= rdPtr + 1'b1;
                outWait     <= 1'b1;
            end else if (outWait) begin
                if (!linkOut.ack) outWait <= 1'b0;
            end else if (!linkOut.req && count != '0) begin
                linkOut.req <= 1'b1;             // Head loaded in the same edge
            end

            count <= count + {{PtrBits{1'b0}}, push} - {{PtrBits{1'b0}}, pop};
        end
    end

endmodule

//--- logic/controller.sv
`timescale 1ns/1ns

module controller (
    input  cpuTypes::InstOp   i_InstOp,
    input  cpuTypes::InstFn   i_InstFn,
    output cpuTypes::CtrlWord o_Ctrl
);

    always_comb begin
        o_Ctrl.aluOp       = cpuTypes::ALU_NOP;     // Default is a no-op
        o_Ctrl.aluSrcB     = 1'b0;
        o_Ctrl.regDst      = 1'b0;
        o_Ctrl.regWrEnable = 1'b0;
        o_Ctrl.zeroExtImm  = 1'b0;

        case (i_InstOp)
            cpuTypes::OP_RTYPE: begin
                o_Ctrl.regDst      = 1'b1;
                o_Ctrl.regWrEnable = 1'b1;
                case (i_InstFn)
                    cpuTypes::FN_ADD: o_Ctrl.aluOp = cpuTypes::ALU_ADD;
                    cpuTypes::FN_SUB: o_Ctrl.aluOp = cpuTypes::ALU_SUB;
                    cpuTypes::FN_AND: o_Ctrl.aluOp = cpuTypes::ALU_AND;
                    cpuTypes::FN_OR:  o_Ctrl.aluOp = cpuTypes::ALU_OR;
                    cpuTypes::FN_SLT: o_Ctrl.aluOp = cpuTypes::ALU_SLT;
                    default:          o_Ctrl.regWrEnable = 1'b0;   // Unknown funct
                endcase
            end
            cpuTypes::OP_ADDI: begin
                o_Ctrl.aluOp       = cpuTypes::ALU_ADD;
                o_Ctrl.aluSrcB     = 1'b1;
                o_Ctrl.regWrEnable = 1'b1;
            end
            cpuTypes::OP_ORI: begin
                o_Ctrl.aluOp       = cpuTypes::ALU_OR;
                o_Ctrl.aluSrcB     = 1'b1;
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.zeroExtImm  = 1'b1;
            end
            default: begin
                // Branches, jumps, loads and stores fall through as no-ops
                o_Ctrl.aluOp = cpuTypes::ALU_NOP;
            end
        endcase
    end

endmodule

//--- logic/regBlock.sv
`timescale 1ns/1ns

module regBlock (
    input  logic        i_Clock,
    input  logic        i_rst,
    input  logic        i_WrEnable,
    input  logic [4:0]  i_WrAddr,
    input  logic [31:0] i_WrData,
    input  logic [4:0]  i_RdAddrA,
    input  logic [4:0]  i_RdAddrB,
    output logic [31:0] o_RdDataA,
    output logic [31:0] o_RdDataB
);

    logic [31:0] regs [32];
    logic        wrLive;                             // Write that actually lands

    assign wrLive = i_WrEnable && (i_WrAddr != 5'd0);

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wrLive) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Write-through so a retiring value is visible in the same cycle
    assign o_RdDataA = (wrLive && i_WrAddr == i_RdAddrA) ? i_WrData : regs[i_RdAddrA];
    assign o_RdDataB = (wrLive && i_WrAddr == i_RdAddrB) ? i_WrData : regs[i_RdAddrB];

endmodule

//--- logic/stageID.sv
`timescale 1ns/1ns

module stageID (
    input  logic              i_Clock,
    input  logic              i_rst,
    instLink.sink             linkIn,
    input  logic              i_RetireValid,
    input  logic [4:0]        i_RetireAddr,
    output logic              o_Valid,
    output logic [31:0]       o_DataA,
    output logic [31:0]       o_DataB,
    output logic [31:0]       o_Imm,
    output logic [4:0]        o_DestAddr,
    output cpuTypes::CtrlWord o_Ctrl,
    output logic [31:0]       o_PcPlus4,
    output logic [4:0]        o_RdAddrA,
    output logic [4:0]        o_RdAddrB,
    input  logic [31:0]       i_RdDataA,
    input  logic [31:0]       i_RdDataB
);

    cpuTypes::CtrlWord ctrl;
    logic [4:0]        rs, rt, rd, dest;
    logic [31:0]       imm;
    logic [31:0]       pending;                      // Scoreboard of writes in flight
    logic [31:0]       pendingNow;
    logic              stall;
    logic              issue;

    assign rs   = linkIn.inst[25:21];
    assign rt   = linkIn.inst[20:16];
    assign rd   = linkIn.inst[15:11];
    assign dest = ctrl.regDst ? rd : rt;
    assign imm  = ctrl.zeroExtImm ? {16'h0000, linkIn.inst[15:0]}
                                  : {{16{linkIn.inst[15]}}, linkIn.inst[15:0]};

    controller ctrlDec (
        .i_InstOp (cpuTypes::InstOp'(linkIn.inst[31:26])),
        .i_InstFn (cpuTypes::InstFn'(linkIn.inst[5:0])),
        .o_Ctrl   (ctrl)
    );

    assign o_RdAddrA = rs;
    assign o_RdAddrB = rt;

    // A retiring write frees its register this very cycle
    assign pendingNow = pending & ~(i_RetireValid ? (32'd1 << i_RetireAddr) : 32'd0);
    assign stall = pendingNow[rs] || (!ctrl.aluSrcB && pendingNow[rt])
                || (ctrl.regWrEnable && pendingNow[dest]);   // Keep writes in order
    assign issue = linkIn.req && !linkIn.ack && !stall;

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            pending    <= '0;
            linkIn.ack <= 1'b0;
            o_Valid    <= 1'b0;
        end else begin
            o_Valid <= issue;
            if (issue && ctrl.regWrEnable && dest != 5'd0)
                pending <= pendingNow | (32'd1 << dest);
            else
                pending <= pendingNow;
            if (issue) linkIn.ack <= 1'b1;
            else if (linkIn.ack && !linkIn.req) linkIn.ack <= 1'b0;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (issue) begin
            o_DataA    <= i_RdDataA;
            o_DataB    <= i_RdDataB;
            o_Imm      <= imm;
            o_DestAddr <= dest;
            o_Ctrl     <= ctrl;
            o_PcPlus4  <= linkIn.pcPlus4;
        end
    end

endmodule

//--- logic/stageEX.sv
`timescale 1ns/1ns

module stageEX (
    input  logic              i_Clock,
    input  logic              i_rst,
    input  logic              i_Valid,
    input  logic [31:0]       i_DataA,
    input  logic [31:0]       i_DataB,
    input  logic [31:0]       i_Imm,
    input  logic [4:0]        i_DestAddr,
    input  cpuTypes::CtrlWord i_Ctrl,
    input  logic [31:0]       i_PcPlus4,
    output logic              o_WrEnable,
    output logic [4:0]        o_WrAddr,
    output logic [31:0]       o_WrData,
    output logic              o_WbValid,
    output logic [4:0]        o_WbAddr,
    output logic [31:0]       o_WbData,
    output logic [31:0]       o_WbPc
);

    logic [31:0] opB;
    logic [31:0] aluResult;

    assign opB = i_Ctrl.aluSrcB ? i_Imm : i_DataB;

    always_comb begin
        case (i_Ctrl.aluOp)
            cpuTypes::ALU_ADD: aluResult = i_DataA + opB;
            cpuTypes::ALU_SUB: aluResult = i_DataA - opB;
            cpuTypes::ALU_AND: aluResult = i_DataA & opB;
            cpuTypes::ALU_OR:  aluResult = i_DataA | opB;
            cpuTypes::ALU_SLT: aluResult = {31'd0, $signed(i_DataA) < $signed(opB)};
            default:           aluResult = '0;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            o_WrEnable <= 1'b0;
        end else begin
            // Register 0 never gets a pending bit, so it never retires
            o_WrEnable <= i_Valid && i_Ctrl.regWrEnable && (i_DestAddr != 5'd0);
        end
    end

    always_ff @(posedge i_Clock) begin
        o_WrAddr <= i_DestAddr;
        o_WrData <= aluResult;
        o_WbPc   <= i_PcPlus4;
    end

    assign o_WbValid = o_WrEnable;                   // Same pulse as the retire
    assign o_WbAddr  = o_WrAddr;
    assign o_WbData  = o_WrData;

endmodule

//--- logic/cpuCore.sv
`timescale 1ns/1ns

module cpuCore #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        i_Clock,
    input  logic        i_rst,
    input  logic        i_InstReq,
    input  logic [31:0] i_InstData,
    output logic        o_InstAck,
    output logic        o_WbValid,
    output logic [4:0]  o_WbAddr,
    output logic [31:0] o_WbData,
    output logic [31:0] o_WbPc
);

    instLink fetchLink ();
    instLink decodeLink ();

    logic              idValid;
    logic [31:0]       idDataA, idDataB, idImm, idPcPlus4;
    logic [4:0]        idDest, rdAddrA, rdAddrB;
    cpuTypes::CtrlWord idCtrl;
    logic [31:0]       rdDataA, rdDataB;
    logic              wrEnable;                     // Also the retire pulse
    logic [4:0]        wrAddr;
    logic [31:0]       wrData;

    fetchUnit fetch (
        .i_Clock (i_Clock), .i_rst (i_rst),
        .i_InstReq (i_InstReq), .i_InstData (i_InstData), .o_InstAck (o_InstAck),
        .linkOut (fetchLink.source)
    );

    instQueue #(.tItem (cpuTypes::FetchItem), .Depth (QUEUE_DEPTH)) queue (
        .i_Clock (i_Clock), .i_rst (i_rst),
        .linkIn (fetchLink.sink), .linkOut (decodeLink.source)
    );

    stageID decode (
        .i_Clock (i_Clock), .i_rst (i_rst), .linkIn (decodeLink.sink),
        .i_RetireValid (wrEnable), .i_RetireAddr (wrAddr),
        .o_Valid (idValid), .o_DataA (idDataA), .o_DataB (idDataB), .o_Imm (idImm),
        .o_DestAddr (idDest), .o_Ctrl (idCtrl), .o_PcPlus4 (idPcPlus4),
        .o_RdAddrA (rdAddrA), .o_RdAddrB (rdAddrB),
        .i_RdDataA (rdDataA), .i_RdDataB (rdDataB)
    );

    regBlock regs (
        .i_Clock (i_Clock), .i_rst (i_rst),
        .i_WrEnable (wrEnable), .i_WrAddr (wrAddr), .i_WrData (wrData),
        .i_RdAddrA (rdAddrA), .i_RdAddrB (rdAddrB),
        .o_RdDataA (rdDataA), .o_RdDataB (rdDataB)
    );

    stageEX execute (
        .i_Clock (i_Clock), .i_rst (i_rst),
        .i_Valid (idValid), .i_DataA (idDataA), .i_DataB (idDataB), .i_Imm (idImm),
        .i_DestAddr (idDest), .i_Ctrl (idCtrl), .i_PcPlus4 (idPcPlus4),
        .o_WrEnable (wrEnable), .o_WrAddr (wrAddr), .o_WrData (wrData),
        .o_WbValid (o_WbValid), .o_WbAddr (o_WbAddr), .o_WbData (o_WbData), .o_WbPc (o_WbPc)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 16
) (
    output logic o_Clock,
    output logic o_rst
);

    initial begin
        o_Clock = 1'b0;
        forever #(PeriodNs / 2) o_Clock = ~o_Clock;
    end

    initial begin
        o_rst = 1'b1;
        repeat (ResetCycles) @(posedge o_Clock);
        @(negedge o_Clock);                          // Release away from the active edge
        o_rst = 1'b0;
    end

endmodule

//--- tb/cpuChecker.sv
`timescale 1ns/1ns

module cpuChecker (
    input  logic        i_Clock,
    input  logic        i_rst,
    input  logic [31:0] i_InstData,
    input  logic        i_InstAck,
    input  logic        i_WbValid,
    input  logic [4:0]  i_WbAddr,
    input  logic [31:0] i_WbData,
    input  logic [31:0] i_WbPc,
    output int          o_AcceptCount,
    output int          o_ExpectCount,
    output int          o_RetireCount,
    output int          o_ValueErrors,
    output int          o_ExtraErrors
);

    logic [31:0] refRegs [32];
    logic [31:0] pcNext = '0;
    logic [4:0]  expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expPc [$];
    logic [4:0]  newAddr;
    logic [31:0] newData;
    logic        newWrites;
    logic [4:0]  headAddr;
    logic [31:0] headData;
    logic [31:0] headPc;
    int          acceptCount = 0;
    int          expectCount = 0;
    int          retireCount = 0;
    int          valueErrors = 0;
    int          extraErrors = 0;

    assign o_AcceptCount = acceptCount;
    assign o_ExpectCount = expectCount;
    assign o_RetireCount = retireCount;
    assign o_ValueErrors = valueErrors;
    assign o_ExtraErrors = extraErrors;

    initial begin
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
    end

    // Executes one instruction on the model state, returns 1 when it writes a register
    function automatic logic refExecute(input logic [31:0] inst, output logic [4:0] wrAddr,
                                        output logic [31:0] wrData);
        logic [31:0] a;
        logic [31:0] b;
        logic        writes;
        a      = refRegs[inst[25:21]];
        b      = refRegs[inst[20:16]];
        writes = 1'b1;
        wrAddr = inst[15:11];
        wrData = '0;
        case (inst[31:26])
            cpuTypes::OP_RTYPE: begin
                case (inst[5:0])
                    cpuTypes::FN_ADD: wrData = a + b;
                    cpuTypes::FN_SUB: wrData = a + ~b + 32'd1;
                    cpuTypes::FN_AND: wrData = a & b;
                    cpuTypes::FN_OR:  wrData = a | b;
                    cpuTypes::FN_SLT: begin
                        // Signs differ means the negative one is smaller
                        if (a[31] != b[31]) wrData = {31'd0, a[31]};
                        else wrData = {31'd0, a < b};
                    end
                    default: writes = 1'b0;
                endcase
            end
            cpuTypes::OP_ADDI: begin
                wrAddr = inst[20:16];
                wrData = a + {{16{inst[15]}}, inst[15:0]};
            end
            cpuTypes::OP_ORI: begin
                wrAddr = inst[20:16];
                wrData = a | {16'h0000, inst[15:0]};
            end
            default: writes = 1'b0;                  // Branches, jumps, memory ops
        endcase
        if (wrAddr == 5'd0) writes = 1'b0;           // Register 0 stays zero
        if (writes) refRegs[wrAddr] = wrData;
        return writes;
    endfunction

    always @(posedge i_InstAck) begin
        if (!i_rst) begin
            acceptCount++;
            pcNext    = pcNext + 32'd4;
            newWrites = refExecute(i_InstData, newAddr, newData);
            if (newWrites) begin
                expAddr.push_back(newAddr);
                expData.push_back(newData);
                expPc.push_back(pcNext);
                expectCount++;
            end
        end
    end

    always @(negedge i_Clock) begin
        if (!i_rst && i_WbValid) begin
            if (expAddr.size() == 0) begin
                extraErrors++;
                $display("** Error at %0t: write-back r%0d = %h pc %h with nothing expected",
                         $time, i_WbAddr, i_WbData, i_WbPc);
            end else begin
                headAddr = expAddr.pop_front();
                headData = expData.pop_front();
                headPc   = expPc.pop_front();
                retireCount++;
                if (i_WbAddr !== headAddr || i_WbData !== headData || i_WbPc !== headPc) begin
                    valueErrors++;
                    $display("** Error at %0t: expected r%0d = %h pc %h, got r%0d = %h pc %h",
                             $time, headAddr, headData, headPc, i_WbAddr, i_WbData, i_WbPc);
                end
            end
        end
    end

endmodule

//--- tb/cpuCoreTb.sv
`timescale 1ns/1ns

module cpuCoreTb;

    localparam int PeriodNs    = 40;
    localparam int ResetCycles = 16;
    localparam int NumInsts    = 200;
    localparam int TimeoutNs   = NumInsts * 30 * PeriodNs + ResetCycles * PeriodNs;

    logic        clock;
    logic        rst;
    logic        instReq;
    logic [31:0] instData;
    logic        instAck;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic [31:0] wbPc;
    int          acceptCount;
    int          expectCount;
    int          retireCount;
    int          valueErrors;
    int          extraErrors;
    int          handshakeErrors;
    logic [31:0] lfsrState;

    clockGen #(.PeriodNs (PeriodNs), .ResetCycles (ResetCycles)) clocks (
        .o_Clock (clock), .o_rst (rst)
    );

    cpuCore #(.QUEUE_DEPTH (4)) i_dut (
        .i_Clock (clock), .i_rst (rst),
        .i_InstReq (instReq), .i_InstData (instData), .o_InstAck (instAck),
        .o_WbValid (wbValid), .o_WbAddr (wbAddr), .o_WbData (wbData), .o_WbPc (wbPc)
    );

    cpuChecker wbCheck (
        .i_Clock (clock), .i_rst (rst), .i_InstData (instData), .i_InstAck (instAck),
        .i_WbValid (wbValid), .i_WbAddr (wbAddr), .i_WbData (wbData), .i_WbPc (wbPc),
        .o_AcceptCount (acceptCount), .o_ExpectCount (expectCount),
        .o_RetireCount (retireCount), .o_ValueErrors (valueErrors),
        .o_ExtraErrors (extraErrors)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) return (state >> 1) ^ 32'h80200003;
        else return state >> 1;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);         // One step per bit
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] makeInst();
        logic [31:0] bits;
        logic [2:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [5:0]  badOp;
        bits = takeBits(3);
        kind = bits[2:0];
        bits = takeBits(9);
        rs   = {2'b00, bits[8:6]};                   // r0..r7 keeps hazards frequent
        rt   = {2'b00, bits[5:3]};
        rd   = {2'b00, bits[2:0]};
        fn   = cpuTypes::FN_ADD;
        case (kind)
            3'd1: fn = cpuTypes::FN_SUB;
            3'd2: fn = cpuTypes::FN_AND;
            3'd3: fn = cpuTypes::FN_OR;
            3'd4: fn = cpuTypes::FN_SLT;
            default: fn = cpuTypes::FN_ADD;
        endcase
        bits = takeBits(16);
        if (kind == 3'd5) return {cpuTypes::OP_ADDI, rs, rt, bits[15:0]};
        if (kind == 3'd6) return {cpuTypes::OP_ORI, rs, rt, bits[15:0]};
        if (kind == 3'd7) begin
            case (bits[1:0])                         // BEQ, LW, SW, J
                2'd0: badOp = 6'h04;
                2'd1: badOp = 6'h23;
                2'd2: badOp = 6'h2B;
                default: badOp = 6'h02;
            endcase
            return {badOp, rs, rt, bits[15:0]};
        end
        return {cpuTypes::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // Host side of the four-phase port
    task automatic sendInst(input logic [31:0] word);
        @(negedge clock);
        instReq  = 1'b1;
        instData = word;
        while (!instAck) @(negedge clock);
        instReq = 1'b0;
        while (instAck) @(negedge clock);
    endtask

    initial begin
        #(TimeoutNs);
        $display("Timeout: the run did not complete within %0d ns", TimeoutNs);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        instReq         = 1'b0;
        instData        = '0;
        handshakeErrors = 0;
        lfsrState       = 32'h7617;
        wait (!rst);
        for (int n = 0; n < NumInsts; n++) sendInst(makeInst());
        while (retireCount < expectCount) @(negedge clock);
        repeat (10) @(negedge clock);                // Give a stray write-back time to show
        if (acceptCount != NumInsts) begin
            handshakeErrors++;
            $display("Accepted %0d instructions but %0d were sent", acceptCount, NumInsts);
        end
        $display("Error counts: %0d wrong value, %0d unexpected write-back, %0d handshake",
                 valueErrors, extraErrors, handshakeErrors);
        if (valueErrors == 0 && extraErrors == 0 && handshakeErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- sources.f
logic/cpuTypes.sv
logic/instLink.sv
logic/fetchUnit.sv
logic/instQueue.sv
logic/controller.sv
logic/regBlock.sv
logic/stageID.sv
logic/stageEX.sv
logic/cpuCore.sv
tb/clockGen.sv
tb/cpuChecker.sv
tb/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module cpuCoreTb -o cpuCoreSim
./obj_dir/cpuCoreSim > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
